//--- dma_pkg.sv
/* Widths, scalar types and response codes shared by the DMA slave controller.
   One command carries a single 64-bit data beat. */
`default_nettype none

package dma_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = 8;
   localparam int SIZE_W = 3;
   localparam int NACK_W = 3;   // Nack counter and QoS limit

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [SIZE_W-1:0] size_t;   // log2 of the transfer bytes

   // Bus response codes, EXOKAY is never returned
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2,   // Alignment or ECC error
      RESP_DECERR = 2'd3    // Address outside DCCM and ICCM
   } resp_t;

   // Error record kept per buffer entry
   typedef struct packed {
      logic err_any;   // Entry failed
      logic err_slv;   // Slave error kind, else decode error
   } err_t;

endpackage

`default_nettype wire

//--- dma_bus_ingress.sv
/* Holding buffers for one write and one read request of the slave bus.
   A write is offered only once both its address and its data are held. */
`timescale 1ns/1ns
`default_nettype none

module dma_bus_ingress
   import dma_pkg::*;
#(
   parameter int TAG_W = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   // Write address and data channels
   input  logic             awvalid,
   output logic             awready,
   input  logic [TAG_W-1:0] awid,
   input  addr_t            awaddr,
   input  size_t            awsize,
   input  logic             wvalid,
   output logic             wready,
   input  data_t            wdata,
   input  strb_t            wstrb,
   // Read address channel
   input  logic             arvalid,
   output logic             arready,
   input  logic [TAG_W-1:0] arid,
   input  addr_t            araddr,
   input  size_t            arsize,
   // Merged command towards the buffer
   input  logic             buf_ready,
   output logic             cmd_valid,
   output logic             cmd_write,
   output logic [TAG_W-1:0] cmd_tag,
   output addr_t            cmd_addr,
   output size_t            cmd_size,
   output data_t            cmd_wdata,
   output strb_t            cmd_strb
);

   logic             aw_held, w_held, ar_held;
   logic [TAG_W-1:0] aw_tag, ar_tag;
   addr_t            aw_addr, ar_addr;
   size_t            aw_size, ar_size;
   data_t            w_data;
   strb_t            w_strb;
   logic             wr_prio;   // Write wins the next tie when set
   logic             wr_full, cmd_sent, wr_sent, rd_sent;

   assign cmd_sent = cmd_valid & buf_ready;
   assign wr_sent  = cmd_sent & cmd_write;
   assign rd_sent  = cmd_sent & ~cmd_write;

   // A held buffer frees in the cycle its command leaves
   assign awready = ~(aw_held & ~wr_sent);
   assign wready  = ~(w_held & ~wr_sent);
   assign arready = ~(ar_held & ~rd_sent);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
         ar_held <= 1'b0;
         wr_prio <= 1'b0;
      end else begin
         if (awvalid && awready)
            aw_held <= 1'b1;
         else if (wr_sent)
            aw_held <= 1'b0;
         if (wvalid && wready)
            w_held <= 1'b1;
         else if (wr_sent)
            w_held <= 1'b0;
         if (arvalid && arready)
            ar_held <= 1'b1;
         else if (rd_sent)
            ar_held <= 1'b0;
         if (cmd_sent)
            wr_prio <= ~wr_prio;   // Round robin, flips on every command
      end
   end

   // ********************
   // Payload registers
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         aw_tag  <= awid;
         aw_addr <= awaddr;
         aw_size <= awsize;
      end
      if (wvalid && wready) begin
         w_data <= wdata;
         w_strb <= wstrb;
      end
      if (arvalid && arready) begin
         ar_tag  <= arid;
         ar_addr <= araddr;
         ar_size <= arsize;
      end
   end

   assign wr_full   = aw_held & w_held;
   assign cmd_valid = wr_full | ar_held;
   assign cmd_write = (wr_full && ar_held) ? wr_prio : wr_full;
   assign cmd_tag   = cmd_write ? aw_tag : ar_tag;
   assign cmd_addr  = cmd_write ? aw_addr : ar_addr;
   assign cmd_size  = cmd_write ? aw_size : ar_size;
   assign cmd_wdata = w_data;
   assign cmd_strb  = w_strb;

   // A held command never disappears while the buffer refuses it
   a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !buf_ready |=> cmd_valid)
      else $error("cmd_valid dropped before the command was taken");

endmodule

`default_nettype wire

//--- dma_cmd_buffer.sv
/* In-order command buffer with write, issue and response pointers.
   DEPTH must be a power of two, reads may finish in any order by tag. */
`timescale 1ns/1ns
`default_nettype none

module dma_cmd_buffer
   import dma_pkg::*;
#(
   parameter int  DEPTH = 4,
   parameter int  TAG_W = 4,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             rst_n,
   // Command from ingress
   input  logic             cmd_valid,
   input  logic             cmd_write,
   input  logic [TAG_W-1:0] cmd_tag,
   input  addr_t            cmd_addr,
   input  size_t            cmd_size,
   input  data_t            cmd_wdata,
   input  strb_t            cmd_strb,
   output logic             buf_ready,
   // Head entry and issue results
   output logic             head_valid,
   output logic             head_pending,
   output logic             head_write,
   output addr_t            head_addr,
   output size_t            head_size,
   output strb_t            head_strb,
   output data_t            head_wdata,
   output logic [PTR_W-1:0] head_tag,
   input  logic             issue_adv,
   input  logic             wr_done,
   input  logic             err_load,
   input  err_t             head_err,
   // Read return, the tag is the entry number
   input  logic             mem_rvalid,
   input  logic [PTR_W-1:0] mem_rtag,
   input  data_t            mem_rdata,
   input  logic             mem_ecc_error,
   // Response channels
   output logic             bvalid,
   input  logic             bready,
   output logic [TAG_W-1:0] bid,
   output resp_t            bresp,
   output logic             rvalid,
   input  logic             rready,
   output logic [TAG_W-1:0] rid,
   output data_t            rdata,
   output resp_t            rresp,
   output logic             rlast
);

   logic [PTR_W-1:0] wr_ptr, iss_ptr, rsp_ptr;
   logic [DEPTH-1:0] ent_valid, ent_pend, ent_done;
   err_t             ent_err   [DEPTH];
   logic             ent_write [DEPTH];
   logic [TAG_W-1:0] ent_tag   [DEPTH];
   addr_t            ent_addr  [DEPTH];
   size_t            ent_size  [DEPTH];
   strb_t            ent_strb  [DEPTH];
   data_t            ent_data  [DEPTH];

   logic [DEPTH-1:0] at_head, ret_hit, err_en, done_en;
   err_t             err_in    [DEPTH];
   logic             cmd_sent, rd_issue, rsp_valid, rsp_sent;
   err_t             rsp_err;

   assign buf_ready = ~ent_valid[wr_ptr];   // Entries free in order
   assign cmd_sent  = cmd_valid & buf_ready;
   assign rd_issue  = issue_adv & ~head_write & ~err_load;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         at_head[i] = (iss_ptr == PTR_W'(i));
         ret_hit[i] = mem_rvalid & (mem_rtag == PTR_W'(i));
         err_en[i]  = (at_head[i] & err_load) | (ret_hit[i] & mem_ecc_error);
         done_en[i] = (at_head[i] & (wr_done | err_load)) | ret_hit[i];
         err_in[i]  = ret_hit[i] ? err_t'{1'b1, 1'b1} : head_err;   // ECC is a slave error
      end
   end

   // ********************
   // Entry status and pointers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ent_valid <= '0;
         ent_pend  <= '0;
         ent_done  <= '0;
         for (int i = 0; i < DEPTH; i++)
            ent_err[i] <= '0;
         wr_ptr  <= '0;
         iss_ptr <= '0;
         rsp_ptr <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (rsp_sent && rsp_ptr == PTR_W'(i)) begin
               ent_valid[i] <= 1'b0;
               ent_pend[i]  <= 1'b0;
               ent_done[i]  <= 1'b0;
               ent_err[i]   <= '0;
            end else begin
               if (cmd_sent && wr_ptr == PTR_W'(i))
                  ent_valid[i] <= 1'b1;
               if (rd_issue && at_head[i])
                  ent_pend[i] <= 1'b1;   // Read out, waiting for its data
               if (done_en[i])
                  ent_done[i] <= 1'b1;
               if (err_en[i])
                  ent_err[i] <= err_in[i];
            end
         end
         if (cmd_sent)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps, DEPTH is a power of two
         if (issue_adv)
            iss_ptr <= iss_ptr + 1'b1;
         if (rsp_sent)
            rsp_ptr <= rsp_ptr + 1'b1;
      end
   end

   // Entry payload, error data is the zero-extended address
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (cmd_sent && wr_ptr == PTR_W'(i)) begin
            ent_write[i] <= cmd_write;
            ent_tag[i]   <= cmd_tag;
            ent_addr[i]  <= cmd_addr;
            ent_size[i]  <= cmd_size;
            ent_strb[i]  <= cmd_strb;
            ent_data[i]  <= cmd_wdata;
         end else if (err_en[i]) begin
            ent_data[i] <= data_t'(ent_addr[i]);
         end else if (ret_hit[i]) begin
            ent_data[i] <= mem_rdata;
         end
      end
   end

   assign head_valid   = ent_valid[iss_ptr] & ~ent_done[iss_ptr];
   assign head_pending = ent_pend[iss_ptr];
   assign head_write   = ent_write[iss_ptr];
   assign head_addr    = ent_addr[iss_ptr];
   assign head_size    = ent_size[iss_ptr];
   assign head_strb    = ent_strb[iss_ptr];
   assign head_wdata   = ent_data[iss_ptr];
   assign head_tag     = iss_ptr;

   // ********************
   // Responses, strictly in command order
   assign rsp_valid = ent_valid[rsp_ptr] & ent_done[rsp_ptr];
   assign rsp_err   = ent_err[rsp_ptr];

   always_comb begin
      if (!rsp_err.err_any)
         bresp = RESP_OKAY;
      else if (rsp_err.err_slv)
         bresp = RESP_SLVERR;
      else
         bresp = RESP_DECERR;
   end

   assign bvalid   = rsp_valid & ent_write[rsp_ptr];
   assign bid      = ent_tag[rsp_ptr];
   assign rvalid   = rsp_valid & ~ent_write[rsp_ptr];
   assign rid      = ent_tag[rsp_ptr];
   assign rdata    = ent_data[rsp_ptr];
   assign rresp    = bresp;
   assign rlast    = 1'b1;   // Single beat only
   assign rsp_sent = (bvalid & bready) | (rvalid & rready);

   for (genvar i = 0; i < DEPTH; i++) begin : g_chk
      a_done_valid: assert property (@(posedge clk) disable iff (!rst_n)
         ent_done[i] |-> ent_valid[i])
         else $error("entry %0d done but not valid", i);
   end

   // Memory must only return data for a read that is still outstanding
   a_rtag_pend: assert property (@(posedge clk) disable iff (!rst_n)
      mem_rvalid |-> ent_valid[mem_rtag] && ent_pend[mem_rtag] && !ent_done[mem_rtag])
      else $error("mem_rtag %0d names no pending read", mem_rtag);

endmodule

`default_nettype wire

//--- dma_mem_issue.sv
/* Checks the head entry against DCCM and ICCM and issues it to one port.
   Ranges must not overlap and must lie below the top of the address space. */
`timescale 1ns/1ns
`default_nettype none

module dma_mem_issue
   import dma_pkg::*;
#(
   parameter int    DEPTH     = 4,
   parameter addr_t DCCM_BASE = 32'hF004_0000,
   parameter addr_t DCCM_SIZE = 32'h0001_0000,
   parameter addr_t ICCM_BASE = 32'hEE00_0000,
   parameter addr_t ICCM_SIZE = 32'h0001_0000,
   localparam int   PTR_W     = $clog2(DEPTH)
) (
   input  logic              clk,
   input  logic              rst_n,
   // Head entry of the buffer
   input  logic              head_valid,
   input  logic              head_pending,
   input  logic              head_write,
   input  addr_t             head_addr,
   input  size_t             head_size,
   input  strb_t             head_strb,
   input  data_t             head_wdata,
   input  logic [PTR_W-1:0]  head_tag,
   output logic              issue_adv,
   output logic              wr_done,
   output logic              err_load,
   output err_t              head_err,
   // Memory request ports
   input  logic              dccm_ready,
   input  logic              iccm_ready,
   output logic              dccm_req,
   output logic              iccm_req,
   output logic [PTR_W-1:0]  mem_tag,
   output addr_t             mem_addr,
   output size_t             mem_size,
   output logic              mem_write,
   output data_t             mem_wdata,
   // QoS
   input  logic [NACK_W-1:0] nack_limit,
   output logic              dccm_stall,
   output logic              iccm_stall
);

   logic              in_dccm, in_iccm, word_dw, strb_lo, strb_hi;
   logic              addr_err, align_err, req_spec, mem_req, accepted, nack_sat;
   logic [NACK_W-1:0] nack_cnt;

   // Unsigned offset compare covers both bounds in one step
   assign in_dccm = (head_addr - DCCM_BASE) < DCCM_SIZE;
   assign in_iccm = (head_addr - ICCM_BASE) < ICCM_SIZE;

   assign word_dw = (head_size == 3'd2) | (head_size == 3'd3);
   assign strb_lo = (head_strb == 8'h0F);
   assign strb_hi = (head_strb == 8'hF0);

   assign addr_err  = ~(in_dccm | in_iccm);
   assign align_err = ~addr_err & (
      head_size[2]                                  |   // Wider than the bus
      ((head_size == 3'd1) & head_addr[0])          |
      ((head_size == 3'd2) & (|head_addr[1:0]))     |
      ((head_size == 3'd3) & (|head_addr[2:0]))     |
      (in_iccm & ~word_dw)                          |   // ICCM is word or dword only
      (in_dccm & head_write & ~word_dw)             |
      (head_write & (head_size == 3'd2) &
         ((head_addr[2] ? head_strb[7:4] : head_strb[3:0]) != 4'hF)) |
      (head_write & (head_size == 3'd3) & ~(strb_lo | strb_hi | (head_strb == 8'hFF))));

   // ********************
   // Issue and error results
   assign req_spec = head_valid & ~head_pending;
   assign err_load = req_spec & (addr_err | align_err);
   assign head_err = '{err_any: addr_err | align_err, err_slv: align_err};
   assign mem_req  = req_spec & ~addr_err & ~align_err;

   assign dccm_req  = mem_req & in_dccm & dccm_ready;
   assign iccm_req  = mem_req & in_iccm & iccm_ready;
   assign accepted  = dccm_req | iccm_req;
   assign issue_adv = accepted | err_load;
   assign wr_done   = accepted & head_write;   // Writes finish on acceptance

   // Half-strobe dword writes go out as a word at that half
   assign mem_tag   = head_tag;
   assign mem_addr  = (head_write && strb_hi) ? {head_addr[31:3], 1'b1, head_addr[1:0]} :
                                                head_addr;
   assign mem_size  = (head_write && (strb_lo || strb_hi)) ? 3'd2 : head_size;
   assign mem_write = head_write;
   assign mem_wdata = head_wdata;

   // Nack counter, one step per cycle a request waits on ready
   always_ff @(posedge clk) begin
      if (!rst_n)
         nack_cnt <= '0;
      else if (accepted)
         nack_cnt <= '0;
      else if (mem_req && nack_cnt < nack_limit)
         nack_cnt <= nack_cnt + 1'b1;
   end

   assign nack_sat   = mem_req & (nack_cnt >= nack_limit);
   assign dccm_stall = nack_sat & in_dccm;
   assign iccm_stall = nack_sat & in_iccm;

   a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
      !(dccm_req && iccm_req))
      else $error("DCCM and ICCM requested together");

endmodule

`default_nettype wire

//--- dma_ctrl_top.sv
/* DMA slave controller for the DCCM and ICCM of a core.
   Both memory ports share one read-return path tagged by buffer entry. */
`timescale 1ns/1ns
`default_nettype none

module dma_ctrl_top
   import dma_pkg::*;
#(
   parameter int    DEPTH     = 4,   // Power of two, 2 to 8
   parameter int    TAG_W     = 4,
   parameter addr_t DCCM_BASE = 32'hF004_0000,
   parameter addr_t DCCM_SIZE = 32'h0001_0000,
   parameter addr_t ICCM_BASE = 32'hEE00_0000,
   parameter addr_t ICCM_SIZE = 32'h0001_0000,
   localparam int   PTR_W     = $clog2(DEPTH)
) (
   input  logic              clk,
   input  logic              rst_n,
   // Write request
   input  logic              awvalid,
   output logic              awready,
   input  logic [TAG_W-1:0]  awid,
   input  addr_t             awaddr,
   input  size_t             awsize,
   input  logic              wvalid,
   output logic              wready,
   input  data_t             wdata,
   input  strb_t             wstrb,
   // Read request
   input  logic              arvalid,
   output logic              arready,
   input  logic [TAG_W-1:0]  arid,
   input  addr_t             araddr,
   input  size_t             arsize,
   // Responses
   output logic              bvalid,
   input  logic              bready,
   output logic [TAG_W-1:0]  bid,
   output resp_t             bresp,
   output logic              rvalid,
   input  logic              rready,
   output logic [TAG_W-1:0]  rid,
   output data_t             rdata,
   output resp_t             rresp,
   output logic              rlast,
   // Memory ports
   output logic              dccm_req,
   output logic              iccm_req,
   input  logic              dccm_ready,
   input  logic              iccm_ready,
   output logic [PTR_W-1:0]  mem_tag,
   output addr_t             mem_addr,
   output size_t             mem_size,
   output logic              mem_write,
   output data_t             mem_wdata,
   input  logic              mem_rvalid,
   input  logic [PTR_W-1:0]  mem_rtag,
   input  data_t             mem_rdata,
   input  logic              mem_ecc_error,
   // Pipeline stall requests
   input  logic [NACK_W-1:0] nack_limit,
   output logic              dccm_stall,
   output logic              iccm_stall
);

   // Ingress to buffer
   logic             cmd_valid, cmd_write, buf_ready;
   logic [TAG_W-1:0] cmd_tag;
   addr_t            cmd_addr;
   size_t            cmd_size;
   data_t            cmd_wdata;
   strb_t            cmd_strb;

   // Buffer head and issue results
   logic             head_valid, head_pending, head_write;
   addr_t            head_addr;
   size_t            head_size;
   strb_t            head_strb;
   data_t            head_wdata;
   logic [PTR_W-1:0] head_tag;
   logic             issue_adv, wr_done, err_load;
   err_t             head_err;

   dma_bus_ingress #(
      .TAG_W(TAG_W)
   ) u_ingress (.*);

   dma_cmd_buffer #(
      .DEPTH(DEPTH),
      .TAG_W(TAG_W)
   ) u_cmd_buffer (.*);

   dma_mem_issue #(
      .DEPTH    (DEPTH),
      .DCCM_BASE(DCCM_BASE),
      .DCCM_SIZE(DCCM_SIZE),
      .ICCM_BASE(ICCM_BASE),
      .ICCM_SIZE(ICCM_SIZE)
   ) u_mem_issue (.*);

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/* DCCM and ICCM model with LFSR-driven ready, 2-cycle read latency and one poisoned dword.
   Writes must be word or dword sized, which the controller guarantees. */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model
   import dma_pkg::*;
#(
   parameter int    PTR_W     = 2,
   parameter addr_t DCCM_BASE = 32'hF004_0000,
   parameter addr_t ICCM_BASE = 32'hEE00_0000,
   parameter addr_t POISON    = 32'hF004_0100
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             hold_ready,   // Forces both readies low
   input  logic             dccm_req,
   input  logic             iccm_req,
   output logic             dccm_ready,
   output logic             iccm_ready,
   input  logic [PTR_W-1:0] mem_tag,
   input  addr_t            mem_addr,
   input  size_t            mem_size,
   input  logic             mem_write,
   input  data_t            mem_wdata,
   output logic             mem_rvalid,
   output logic [PTR_W-1:0] mem_rtag,
   output data_t            mem_rdata,
   output logic             mem_ecc_error
);

   data_t            dccm [8192];
   data_t            iccm [8192];
   logic [15:0]      lfsr = 16'd49;
   logic [12:0]      idx;
   logic             acc_rd, acc_ecc, p_valid, p_ecc;
   logic [PTR_W-1:0] acc_tag, p_tag;
   data_t            acc_word, p_data;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   initial begin
      // Fill is the dword address and its inverse
      for (int i = 0; i < 8192; i++) begin
         dccm[i] = {DCCM_BASE + 32'(i * 8), ~(DCCM_BASE + 32'(i * 8))};
         iccm[i] = {ICCM_BASE + 32'(i * 8), ~(ICCM_BASE + 32'(i * 8))};
      end
      dccm_ready    = 1'b0;
      iccm_ready    = 1'b0;
      mem_rvalid    = 1'b0;
      mem_rtag      = '0;
      mem_rdata     = '0;
      mem_ecc_error = 1'b0;
      p_valid       = 1'b0;
   end

   // ********************
   // Request seen mid-cycle is the one accepted on the next edge
   always @(negedge clk) begin
      idx      = mem_addr[15:3];
      acc_rd   = (dccm_req | iccm_req) & ~mem_write;
      acc_tag  = mem_tag;
      acc_ecc  = dccm_req & (mem_addr[31:3] == POISON[31:3]);
      acc_word = dccm_req ? dccm[idx] : iccm[idx];
      if ((dccm_req | iccm_req) & mem_write) begin
         if (mem_size == 3'd3)
            acc_word = mem_wdata;
         else if (mem_addr[2])
            acc_word[63:32] = mem_wdata[63:32];   // Upper word lanes
         else
            acc_word[31:0] = mem_wdata[31:0];
         if (dccm_req)
            dccm[idx] = acc_word;
         else
            iccm[idx] = acc_word;
      end
   end

   // Two stages, then the read data leaves
   always @(posedge clk) begin
      #1;
      mem_rvalid    = p_valid & rst_n;
      mem_rtag      = p_tag;
      mem_rdata     = p_data;
      mem_ecc_error = p_ecc & p_valid;
      p_valid       = acc_rd & rst_n;
      p_tag         = acc_tag;
      p_data        = acc_word;
      p_ecc         = acc_ecc;
      lfsr          = lfsr_next(lfsr);
      dccm_ready    = lfsr[0] & ~hold_ready;
      lfsr          = lfsr_next(lfsr);
      iccm_ready    = lfsr[0] & ~hold_ready;
   end

endmodule

`default_nettype wire

//--- tb_dma_ctrl.sv
/* Table-driven testbench for the DMA slave controller with in-order response checks.
   A command is offered only after the previous one entered the buffer. */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_ctrl
   import dma_pkg::*;
();

   localparam int NROWS       = 24;
   localparam int BURST_FIRST = 14;   // Rows from here on see throttled bready/rready
   localparam int LIMIT       = NROWS * 40 + 10;
   localparam int OP_RD       = 0;
   localparam int OP_WR       = 1;
   localparam int OP_STALL    = 2;   // DCCM write with memory ready held low

   logic              clk = 1'b0;
   logic              rst_n = 1'b0;
   logic              awvalid = 1'b0, wvalid = 1'b0, arvalid = 1'b0;
   logic              awready, wready, arready;
   logic [3:0]        awid = '0, arid = '0;
   addr_t             awaddr = '0, araddr = '0;
   size_t             awsize = '0, arsize = '0;
   data_t             wdata = '0;
   strb_t             wstrb = '0;
   logic              bvalid, rvalid, rlast;
   logic              bready = 1'b1, rready = 1'b1;
   logic [3:0]        bid, rid;
   resp_t             bresp, rresp;
   data_t             rdata, mem_wdata, mem_rdata;
   logic              dccm_req, iccm_req, dccm_ready, iccm_ready, dccm_stall, iccm_stall;
   logic [1:0]        mem_tag, mem_rtag;
   addr_t             mem_addr;
   size_t             mem_size;
   logic              mem_write, mem_rvalid, mem_ecc_error;
   logic [NACK_W-1:0] nack_limit = 3'd3;
   logic              hold_ready = 1'b0, throttle = 1'b0;

   string             row_name [NROWS];
   int                row_op   [NROWS];
   logic [3:0]        row_id   [NROWS];
   addr_t             row_addr [NROWS];
   size_t             row_size [NROWS];
   strb_t             row_strb [NROWS];
   resp_t             row_resp [NROWS];
   data_t             row_data [NROWS];   // Write data, or expected read data
   int                n_rows = 0;
   int                exp_q [$];          // Rows in acceptance order
   int                checked = 0, tests_run = 0, tests_failed = 0, err_count = 0;
   int                cycles = 0;
   logic [15:0]       lfsr = 16'd49;

   always #4 clk = ~clk;

   dma_ctrl_top #(.DEPTH(4), .TAG_W(4)) dut0 (.*);
   tb_mem_model #(.PTR_W(2)) mem0 (.*);

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic add_row(input string name, input int op, input logic [3:0] id,
                          input addr_t addr, input size_t size, input strb_t strb,
                          input resp_t resp, input data_t data);
      row_name[n_rows] = name;
      row_op[n_rows]   = op;
      row_id[n_rows]   = id;
      row_addr[n_rows] = addr;
      row_size[n_rows] = size;
      row_strb[n_rows] = strb;
      row_resp[n_rows] = resp;
      row_data[n_rows] = data;
      n_rows++;
   endtask

   task automatic load_table();
      add_row("dccm_wr_dw", OP_WR, 1, 32'hF0040008, 3, 8'hFF, RESP_OKAY, 64'h1122334455667788);
      add_row("dccm_rd_dw", OP_RD, 2, 32'hF0040008, 3, 8'h00, RESP_OKAY, 64'h1122334455667788);
      add_row("dccm_wr_hi", OP_WR, 3, 32'hF004000C, 2, 8'hF0, RESP_OKAY, 64'hAABBCCDD00000000);
      add_row("dccm_rd_hi", OP_RD, 4, 32'hF0040008, 3, 8'h00, RESP_OKAY, 64'hAABBCCDD55667788);
      add_row("iccm_wr_w", OP_WR, 5, 32'hEE000010, 2, 8'h0F, RESP_OKAY, 64'h00000000CAFEF00D);
      add_row("iccm_rd_w", OP_RD, 6, 32'hEE000010, 2, 8'h00, RESP_OKAY, 64'hEE000010CAFEF00D);
      add_row("iccm_rd_hw", OP_RD, 7, 32'hEE000020, 1, 8'h00, RESP_SLVERR, 64'hEE000020);
      add_row("dec_rd", OP_RD, 8, 32'h10000000, 3, 8'h00, RESP_DECERR, 64'h10000000);
      add_row("dec_wr", OP_WR, 9, 32'h10000008, 3, 8'hFF, RESP_DECERR, 64'h5A5A5A5A5A5A5A5A);
      add_row("misalign_rd", OP_RD, 10, 32'hF0040042, 2, 8'h00, RESP_SLVERR, 64'hF0040042);
      add_row("bad_strb_wr", OP_WR, 11, 32'hF0040040, 3, 8'h3C, RESP_SLVERR, '1);
      add_row("unchanged_rd", OP_RD, 12, 32'hF0040040, 3, 8'h00, RESP_OKAY, 64'hF00400400FFBFFBF);
      add_row("ecc_rd", OP_RD, 13, 32'hF0040100, 3, 8'h00, RESP_SLVERR, 64'hF0040100);
      add_row("stall_wr", OP_STALL, 14, 32'hF0040200, 3, 8'hFF, RESP_OKAY, 64'h0123456789ABCDEF);
      // Mixed burst longer than the buffer
      add_row("burst_wr0", OP_WR, 1, 32'hF0040300, 3, 8'hFF, RESP_OKAY, 64'h1111111111111111);
      add_row("burst_wr1", OP_WR, 2, 32'hEE000300, 3, 8'hFF, RESP_OKAY, 64'h2222222222222222);
      add_row("burst_rd0", OP_RD, 3, 32'hF0040300, 3, 8'h00, RESP_OKAY, 64'h1111111111111111);
      add_row("burst_rd1", OP_RD, 4, 32'hEE000300, 3, 8'h00, RESP_OKAY, 64'h2222222222222222);
      add_row("burst_rd2", OP_RD, 5, 32'hF0040308, 3, 8'h00, RESP_OKAY, 64'hF00403080FFBFCF7);
      add_row("burst_err", OP_RD, 6, 32'h20000000, 3, 8'h00, RESP_DECERR, 64'h20000000);
      add_row("burst_wr2", OP_WR, 7, 32'hF0040310, 2, 8'h0F, RESP_OKAY, 64'h000000003333AAAA);
      add_row("burst_rd3", OP_RD, 8, 32'hF0040310, 3, 8'h00, RESP_OKAY, 64'hF00403103333AAAA);
      add_row("burst_rd4", OP_RD, 9, 32'hEE000308, 3, 8'h00, RESP_OKAY, 64'hEE00030811FFFCF7);
      add_row("burst_rd5", OP_RD, 15, 32'hF0040300, 3, 8'h00, RESP_OKAY, 64'h1111111111111111);
   endtask

   task automatic check_field(input string test, input string field, input logic [63:0] exp,
                              input logic [63:0] act, inout int errs);
      assert (exp === act) else begin
         $display("ERROR %s %s expected %h actual %h", test, field, exp, act);
         errs++;
      end
   endtask

   // ********************
   // Driver that sends one row at a time
   task automatic send_row(input int i);
      logic aw_left, w_left, ar_left;
      aw_left = (row_op[i] != OP_RD);
      w_left  = aw_left;
      ar_left = (row_op[i] == OP_RD);
      do @(negedge clk); while (!(awready && wready && arready));   // Earlier command sent
      @(posedge clk);
      #1;
      {awid, arid, awaddr, araddr}   = {row_id[i], row_id[i], row_addr[i], row_addr[i]};
      {awsize, arsize, wdata, wstrb} = {row_size[i], row_size[i], row_data[i], row_strb[i]};
      while (aw_left || w_left || ar_left) begin
         {awvalid, wvalid, arvalid} = {aw_left, w_left, ar_left};
         @(negedge clk);
         aw_left = aw_left & ~awready;
         w_left  = w_left & ~wready;
         ar_left = ar_left & ~arready;
         @(posedge clk);
         #1;
      end
      {awvalid, wvalid, arvalid} = 3'b000;
      exp_q.push_back(i);
   endtask

   task automatic stall_check(input int i);
      int n;
      int errs;
      n    = 0;
      errs = 0;
      do @(negedge clk); while (exp_q.size() != 0);
      hold_ready = 1'b1;
      send_row(i);
      do begin
         @(negedge clk);
         n++;
      end while (!dccm_stall && n < 40);
      // Two cycles into the buffer and then nack_limit waiting cycles
      check_field("stall_timing", "stall delay", nack_limit + 2, n, errs);
      check_field("stall_timing", "iccm_stall", 0, iccm_stall, errs);
      hold_ready = 1'b0;
      do @(negedge clk); while (!dccm_req);
      @(negedge clk);
      check_field("stall_timing", "dccm_stall after accept", 0, dccm_stall, errs);
      tests_run++;
      err_count += errs;
      if (errs == 0) begin
         $display("PASS stall_timing");
      end else begin
         $display("FAIL stall_timing");
         tests_failed++;
      end
   endtask

   // ********************
   // Response checker
   task automatic check_response(input logic is_b);
      int i;
      int errs;
      errs = 0;
      assert (exp_q.size() > 0) else begin
         $display("a response arrived with no request outstanding");
         err_count++;
      end
      if (exp_q.size() > 0) begin
         i = exp_q.pop_front();
         check_field(row_name[i], "B channel", row_op[i] != OP_RD, is_b, errs);
         if (is_b) begin
            check_field(row_name[i], "bid", row_id[i], bid, errs);
            check_field(row_name[i], "bresp", row_resp[i], bresp, errs);
         end else begin
            check_field(row_name[i], "rid", row_id[i], rid, errs);
            check_field(row_name[i], "rresp", row_resp[i], rresp, errs);
            check_field(row_name[i], "rdata", row_data[i], rdata, errs);
            check_field(row_name[i], "rlast", 1, rlast, errs);
         end
         checked++;
         tests_run++;
         err_count += errs;
         if (errs == 0) begin
            $display("PASS %s", row_name[i]);
         end else begin
            $display("FAIL %s", row_name[i]);
            tests_failed++;
         end
      end
   endtask

   always @(negedge clk) begin
      if (rst_n && ((bvalid && bready) || (rvalid && rready)))
         check_response(bvalid && bready);
   end

   always @(posedge clk) begin
      #1;
      lfsr   = lfsr_next(lfsr);
      bready = throttle ? lfsr[0] : 1'b1;
      lfsr   = lfsr_next(lfsr);
      rready = throttle ? lfsr[0] : 1'b1;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("timeout after %0d cycles, %0d of %0d responses seen", cycles, checked, n_rows);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      load_table();
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         throttle = (i >= BURST_FIRST);
         if (row_op[i] == OP_STALL)
            stall_check(i);
         else
            send_row(i);
      end
      do @(negedge clk); while (checked < n_rows);
      throttle = 1'b0;
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
      if (err_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
dma_pkg.sv
dma_bus_ingress.sv
dma_cmd_buffer.sv
dma_mem_issue.sv
dma_ctrl_top.sv
tb_mem_model.sv
tb_dma_ctrl.sv
